// ==== logic/dataCache.sv ====
`include "lsu_defines.svh"

module dataCache (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    output logic                   cacheReady,
    input  logic                   issueValid,
    input  lsuPkg::lsuReq          issueReq,
    output logic                   memValid,
    output memBusPkg::memReq       memReqOut,
    input  logic                   memDone,
    input  logic [`LSU_DATA_W-1:0] memRdata,
    output logic                   respValid,
    output lsuPkg::lsuResp         resp
);
    localparam int lines = `LSU_CACHE_LINES;
    localparam int dataW = `LSU_DATA_W;
    localparam int offW = $clog2(dataW / 8);
    localparam int idxW = $clog2(lines);
    localparam int tagW = `LSU_ADDR_W - idxW - offW;

    typedef enum logic [1:0] {idle, waitStore, waitFill} cacheState;

    cacheState state;
    logic occupied;
    logic respPending;
    lsuPkg::lsuReq held;
    logic [lines-1:0] lineValid;
    logic [tagW-1:0] lineTag [lines];
    logic [dataW-1:0] lineData [lines];

    logic [offW-1:0] off;
    logic [idxW-1:0] idx;
    logic [tagW-1:0] addrTag;
    logic hit;
    logic accept;
    logic lookup;
    logic finish;

    assign off = held.addr[offW-1:0];
    assign idx = held.addr[offW +: idxW];
    assign addrTag = held.addr[`LSU_ADDR_W-1 -: tagW];
    assign hit = lineValid[idx] && (lineTag[idx] == addrTag);

    assign accept = rdy && issueValid && !occupied;
    assign lookup = rdy && occupied && (state == idle);
    assign finish = rdy && memDone && (state != idle);

    // Strobe shows only in a running cycle, so a pause cannot swallow it
    assign respValid = respPending && rdy;

    function automatic logic [dataW-1:0] lenMask(input memBusPkg::accessLen len);
        case (len)
            memBusPkg::lenByte: return dataW'(8'hff);
            memBusPkg::lenHalf: return dataW'(16'hffff);
            default:            return '1;
        endcase
    endfunction

    function automatic logic [dataW-1:0] extractBytes(input logic [dataW-1:0] word,
                                                      input logic [offW-1:0] byteOff,
                                                      input memBusPkg::accessLen len);
        return (word >> {byteOff, 3'b000}) & lenMask(len);  // Zero-extended
    endfunction

    function automatic logic [dataW-1:0] mergeBytes(input logic [dataW-1:0] old,
                                                    input logic [dataW-1:0] wdata,
                                                    input logic [offW-1:0] byteOff,
                                                    input memBusPkg::accessLen len);
        logic [dataW-1:0] mask;
        mask = lenMask(len) << {byteOff, 3'b000};
        return (old & ~mask) | ((wdata << {byteOff, 3'b000}) & mask);
    endfunction

    always_comb begin
        if (rst) begin
            cacheReady = 1'b1;  // Held high in reset
        end else begin
            cacheReady = rdy && !occupied;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            occupied <= 1'b0;
            memValid <= 1'b0;
            respPending <= 1'b0;
            lineValid <= '0;
        end else if (rdy) begin
            memValid <= 1'b0;
            respPending <= 1'b0;
            if (accept) begin
                occupied <= 1'b1;
            end
            if (lookup) begin
                if (held.kind == memBusPkg::accStore) begin
                    memValid <= 1'b1;  // Write-through on hit and miss alike
                    state <= waitStore;
                end else if (hit) begin
                    respPending <= 1'b1;
                    occupied <= 1'b0;
                end else begin
                    memValid <= 1'b1;
                    state <= waitFill;
                end
            end
            if (finish) begin
                respPending <= 1'b1;
                occupied <= 1'b0;
                state <= idle;
                if (state == waitFill) begin
                    lineValid[idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= issueReq;
        end
        if (lookup) begin
            if (held.kind == memBusPkg::accStore) begin
                memReqOut <= '{kind: held.kind, len: held.len,
                               addr: held.addr, wdata: held.wdata};
                if (hit) begin
                    lineData[idx] <= mergeBytes(lineData[idx], held.wdata, off, held.len);
                end
            end else if (hit) begin
                resp <= '{tag: held.tag, data: extractBytes(lineData[idx], off, held.len)};
            end else begin
                // Whole word for the fill
                memReqOut <= '{kind: memBusPkg::accLoad, len: memBusPkg::lenWord,
                               addr: {held.addr[`LSU_ADDR_W-1:offW], {offW{1'b0}}},
                               wdata: '0};
            end
        end
        if (finish) begin
            resp.tag <= held.tag;
            if (state == waitFill) begin
                resp.data <= extractBytes(memRdata, off, held.len);
                lineTag[idx] <= addrTag;
                lineData[idx] <= memRdata;
            end else begin
                resp.data <= '0;
            end
        end
    end

endmodule

// ==== logic/loadStoreBuffer.sv ====
`include "lsu_defines.svh"

module loadStoreBuffer (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,
    input  logic          reqValid,
    input  lsuPkg::lsuReq req,
    output logic          full,
    input  logic          cacheReady,
    output logic          issueValid,
    output lsuPkg::lsuReq issueReq
);
    localparam int depth = `LSU_QUEUE_DEPTH;
    localparam int ptrW = $clog2(depth);
    localparam int cntW = ptrW + 1;

    lsuPkg::lsuReq entries [depth];
    logic [ptrW-1:0] head;
    logic [ptrW-1:0] tail;
    logic [cntW-1:0] count;
    logic push;
    logic pop;

    assign full = (count == cntW'(depth)) || !rdy;  // Paused counts as full
    assign push = rdy && reqValid && !full;

    // Oldest entry goes out whenever the cache can take it
    assign issueValid = cacheReady && (count != '0);
    assign issueReq = entries[head];
    assign pop = issueValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else if (rdy) begin
            if (push) begin
                tail <= tail + 1'b1;  // Wraps at depth
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + cntW'(push) - cntW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= req;
        end
    end

endmodule

// ==== logic/lsuPkg.sv ====
`include "lsu_defines.svh"

package lsuPkg;

    typedef logic [`LSU_TAG_W-1:0] lsuTag;

    typedef struct packed {
        memBusPkg::accessKind   kind;
        memBusPkg::accessLen    len;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] wdata;
        lsuTag                  tag;
    } lsuReq;

    // Stores come back with zero data
    typedef struct packed {
        lsuTag                  tag;
        logic [`LSU_DATA_W-1:0] data;
    } lsuResp;

endpackage

// ==== logic/lsuTop.sv ====
`include "lsu_defines.svh"

module lsuTop (
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,
    input  logic           reqValid,
    input  lsuPkg::lsuReq  req,
    output logic           full,
    output logic           respValid,
    output lsuPkg::lsuResp resp
);
    logic cacheReady;
    logic issueValid;
    lsuPkg::lsuReq issueReq;
    logic memValid;
    memBusPkg::memReq memReqBus;
    logic memDone;
    logic [`LSU_DATA_W-1:0] memRdata;

    loadStoreBuffer buffer (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .reqValid   (reqValid),
        .req        (req),
        .full       (full),
        .cacheReady (cacheReady),
        .issueValid (issueValid),
        .issueReq   (issueReq)
    );

    dataCache cache (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .cacheReady (cacheReady),
        .issueValid (issueValid),
        .issueReq   (issueReq),
        .memValid   (memValid),
        .memReqOut  (memReqBus),
        .memDone    (memDone),
        .memRdata   (memRdata),
        .respValid  (respValid),
        .resp       (resp)
    );

    memCtrl ctrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .memValid (memValid),
        .memReqIn (memReqBus),
        .memDone  (memDone),
        .memRdata (memRdata)
    );

endmodule

// ==== logic/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_TAG_W 4

// Sizes are powers of two
`define LSU_QUEUE_DEPTH 4
`define LSU_CACHE_LINES 16
`define LSU_MEM_BYTES 256

`endif

// ==== logic/memBusPkg.sv ====
`include "lsu_defines.svh"

package memBusPkg;

    typedef enum logic {
        accLoad  = 1'b0,
        accStore = 1'b1
    } accessKind;

    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen;  // Value is the byte count

    // Cache to controller
    typedef struct packed {
        accessKind              kind;
        accessLen               len;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] wdata;
    } memReq;

endpackage

// ==== logic/memCtrl.sv ====
`include "lsu_defines.svh"

module memCtrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   memValid,
    input  memBusPkg::memReq       memReqIn,
    output logic                   memDone,
    output logic [`LSU_DATA_W-1:0] memRdata
);
    localparam int memBytes = `LSU_MEM_BYTES;
    localparam int addrW = $clog2(memBytes);
    localparam int byteW = $clog2(`LSU_DATA_W / 8);

    typedef enum logic [1:0] {clearing, idle, gap, transfer} ctrlState;

    ctrlState state;
    logic [7:0] ram [memBytes];
    logic [addrW-1:0] clearAddr;
    logic [byteW-1:0] count;
    memBusPkg::memReq held;
    logic [2:0] lastByte;
    logic [addrW-1:0] byteAddr;

    assign lastByte = held.len - 3'd1;
    assign byteAddr = held.addr[addrW-1:0] + addrW'(count);  // Little-endian walk

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= clearing;
            clearAddr <= '0;
            count <= '0;
            memDone <= 1'b0;
        end else if (rdy) begin
            memDone <= 1'b0;
            case (state)
                clearing: begin
                    clearAddr <= clearAddr + 1'b1;
                    if (clearAddr == addrW'(memBytes - 1)) begin
                        state <= idle;
                    end
                end
                idle: begin
                    count <= '0;
                    if (memValid) begin
                        state <= gap;
                    end
                end
                gap: begin
                    count <= count + 1'b1;
                    if (count == byteW'(1)) begin  // Two dead cycles
                        count <= '0;
                        state <= transfer;
                    end
                end
                transfer: begin
                    count <= count + 1'b1;
                    if (count == lastByte[byteW-1:0]) begin
                        memDone <= 1'b1;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (state == clearing) begin
                ram[clearAddr] <= 8'h00;
            end
            if (state == idle && memValid) begin
                held <= memReqIn;
                memRdata <= '0;  // Unused upper bytes read as zero
            end
            if (state == transfer) begin
                if (held.kind == memBusPkg::accStore) begin
                    ram[byteAddr] <= held.wdata[{count, 3'b000} +: 8];
                end else begin
                    memRdata[{count, 3'b000} +: 8] <= ram[byteAddr];
                end
            end
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsuTb -f verilog.f -o lsuSim

./obj_dir/lsuSim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"

// ==== verification/clockGen.sv ====
module clockGen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // Period 4
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== verification/lsuTb.sv ====
`include "lsu_defines.svh"

module lsuTb;
    localparam int memBytes = `LSU_MEM_BYTES;
    localparam int randomCount = 200;
    localparam int totalReqs = 1 + 10 + 4 + 20 + randomCount + 9;

    logic clk;
    logic rst;
    logic rdy;
    logic reqValid;
    lsuPkg::lsuReq req;
    logic full;
    logic respValid;
    lsuPkg::lsuResp resp;

    lsuPkg::lsuResp expQ [$];  // Expected responses in request order
    logic [7:0] refMem [memBytes];
    lsuPkg::lsuTag nextTag;
    string testName;
    int testChecks;
    int testErrors;
    int totalChecks;
    int totalErrors;
    int testsRun;
    int testsFailed;

    clockGen clocks (
        .clk (clk),
        .rst (rst)
    );

    lsuTop dut (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .reqValid  (reqValid),
        .req       (req),
        .full      (full),
        .respValid (respValid),
        .resp      (resp)
    );

    bind dataCache lsuAssertions checks (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .cacheReady (cacheReady),
        .issueValid (issueValid),
        .respValid  (respValid),
        .memValid   (memValid),
        .memDone    (memDone)
    );

    // Little-endian byte memory, loads zero-extended, stores answer zero
    function automatic lsuPkg::lsuResp refModel(input lsuPkg::lsuReq r);
        lsuPkg::lsuResp out;
        int n;
        int a;
        out.tag = r.tag;
        out.data = '0;
        n = int'(r.len);  // Enum value is the byte count
        for (int i = 0; i < n; i++) begin
            a = (int'(r.addr) + i) % memBytes;
            if (r.kind == memBusPkg::accStore) begin
                refMem[a] = r.wdata[8*i +: 8];
            end else begin
                out.data[8*i +: 8] = refMem[a];
            end
        end
        return out;
    endfunction

    task automatic reportProblem(input string what);
        testErrors++;
        $display("[ERROR] %s: %s", testName, what);
    endtask

    task automatic checkTag(input lsuPkg::lsuTag expected, input lsuPkg::lsuTag actual);
        testChecks++;
        if (actual !== expected) begin
            testErrors++;
            $display("[FAIL] %s tag: expected %0h, actual %0h", testName, expected, actual);
        end
    endtask

    task automatic checkData(input logic [`LSU_DATA_W-1:0] expected,
                             input logic [`LSU_DATA_W-1:0] actual);
        testChecks++;
        if (actual !== expected) begin
            testErrors++;
            $display("[FAIL] %s data: expected %08h, actual %08h", testName, expected, actual);
        end
    endtask

    // Strobe only after a cycle with full low and no strobe of our own
    task automatic sendReq(input memBusPkg::accessKind kind, input memBusPkg::accessLen len,
                           input logic [31:0] addr, input logic [31:0] wdata);
        lsuPkg::lsuReq r;
        r = '{kind: kind, len: len, addr: addr, wdata: wdata, tag: nextTag};
        nextTag = nextTag + 1'b1;
        @(negedge clk);
        while (full) begin
            @(negedge clk);
        end
        expQ.push_back(refModel(r));
        @(posedge clk);
        reqValid <= 1'b1;
        req <= r;
        @(posedge clk);
        reqValid <= 1'b0;
    endtask

    task automatic sendRandom();
        memBusPkg::accessLen len;
        memBusPkg::accessKind kind;
        logic [31:0] addr;
        case ($urandom % 3)
            0: len = memBusPkg::lenByte;
            1: len = memBusPkg::lenHalf;
            default: len = memBusPkg::lenWord;
        endcase
        kind = ($urandom % 2 == 1) ? memBusPkg::accStore : memBusPkg::accLoad;
        addr = 32'(($urandom % memBytes) & ~(int'(len) - 1));  // Aligned to length
        sendReq(kind, len, addr, $urandom);
    endtask

    task automatic startTest(input string name);
        testName = name;
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic endTest();
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        $display("Test %-12s %0d checks, %0d errors", testName, testChecks, testErrors);
        testsRun++;
        totalChecks += testChecks;
        totalErrors += testErrors;
        if (testErrors != 0) begin
            testsFailed++;
        end
    endtask

    always @(negedge clk) begin
        lsuPkg::lsuResp expected;
        if (!rst) begin
            if (respValid && !rdy) begin
                reportProblem("response strobe while rdy is low");
            end
            if (respValid) begin
                if (expQ.size() == 0) begin
                    reportProblem("response arrived with no request outstanding");
                end else begin
                    expected = expQ.pop_front();
                    checkTag(expected.tag, resp.tag);
                    checkData(expected.data, resp.data);
                end
            end
        end
    end

    initial begin
        repeat (totalReqs * 200 + memBytes + 10) @(posedge clk);
        $display("Timeout: responses still missing after %0d requests' worth of cycles",
                 totalReqs);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int seed;
        int pauseLen;
        logic [31:0] addr;
        seed = $urandom(7);
        rdy = 1'b1;
        reqValid = 1'b0;
        req = '0;
        nextTag = '0;
        totalChecks = 0;
        totalErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        for (int i = 0; i < memBytes; i++) begin
            refMem[i] = 8'h00;
        end

        wait (rst == 1'b0);
        @(negedge clk);
        startTest("resetState");
        testChecks += 2;
        if (respValid !== 1'b0) begin
            reportProblem("respValid is high right after reset");
        end
        if (full !== 1'b0) begin
            reportProblem("full is high right after reset");
        end
        repeat (memBytes + 4) @(posedge clk);  // RAM clear
        sendReq(memBusPkg::accLoad, memBusPkg::lenWord, 32'h10, '0);
        endTest();

        startTest("writeRead");
        sendReq(memBusPkg::accStore, memBusPkg::lenWord, 32'h20, 32'h1122_3344);
        sendReq(memBusPkg::accStore, memBusPkg::lenHalf, 32'h22, 32'h0000_aabb);
        sendReq(memBusPkg::accStore, memBusPkg::lenByte, 32'h21, 32'h0000_00cc);
        sendReq(memBusPkg::accLoad, memBusPkg::lenWord, 32'h20, '0);
        sendReq(memBusPkg::accLoad, memBusPkg::lenHalf, 32'h20, '0);
        sendReq(memBusPkg::accLoad, memBusPkg::lenHalf, 32'h22, '0);
        for (int i = 0; i < 4; i++) begin
            sendReq(memBusPkg::accLoad, memBusPkg::lenByte, 32'(32'h20 + i), '0);
        end
        endTest();

        startTest("missHit");
        sendReq(memBusPkg::accLoad, memBusPkg::lenWord, 32'h84, '0);
        sendReq(memBusPkg::accStore, memBusPkg::lenWord, 32'h84, 32'hdead_beef);
        sendReq(memBusPkg::accLoad, memBusPkg::lenWord, 32'h84, '0);
        sendReq(memBusPkg::accLoad, memBusPkg::lenWord, 32'h84, '0);
        endTest();

        // Stride of 64 bytes lands on the same line
        startTest("conflict");
        for (int i = 0; i < 4; i++) begin
            addr = 32'(32'h08 + 32'h40 * i);
            sendReq(memBusPkg::accStore, memBusPkg::lenWord, addr, $urandom);
            sendReq(memBusPkg::accLoad, memBusPkg::lenWord, addr, '0);
            sendReq(memBusPkg::accStore, memBusPkg::lenWord, addr, $urandom);  // Hits
            sendReq(memBusPkg::accLoad, memBusPkg::lenWord, addr, '0);
        end
        for (int i = 0; i < 4; i++) begin
            sendReq(memBusPkg::accLoad, memBusPkg::lenWord, 32'(32'h08 + 32'h40 * i), '0);
        end
        endTest();

        startTest("randomMix");
        for (int i = 0; i < randomCount; i++) begin
            sendRandom();
        end
        endTest();

        startTest("pause");
        for (int round = 0; round < 3; round++) begin
            for (int k = 0; k < 3; k++) begin
                sendRandom();
            end
            pauseLen = 5 + int'($urandom % 20);
            @(posedge clk);
            rdy <= 1'b0;
            repeat (pauseLen) @(posedge clk);
            rdy <= 1'b1;
        end
        endTest();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/lsu_assertions.sv ====
module lsuAssertions (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic cacheReady,
    input logic issueValid,
    input logic respValid,
    input logic memValid,
    input logic memDone
);
    logic memBusy;  // Request sent to the controller and not yet done

    always_ff @(posedge clk) begin
        if (rst) begin
            memBusy <= 1'b0;
        end else if (rdy) begin
            if (memDone) begin
                memBusy <= 1'b0;
            end
            if (memValid) begin
                memBusy <= 1'b1;
            end
        end
    end

    // An issued request must occupy the cache in the next cycle
    issueTaken: assert property (@(posedge clk) disable iff (rst)
        issueValid |=> !cacheReady)
        else $error("issue strobe not taken by the cache");

    respOneCycle: assert property (@(posedge clk) disable iff (rst)
        respValid |=> !respValid)
        else $error("response strobe lasted more than one cycle");

    oneMemRequest: assert property (@(posedge clk) disable iff (rst)
        (memValid && rdy) |-> !memBusy)
        else $error("memory request raised again before memDone");

endmodule

// ==== verilog.f ====
+incdir+logic
logic/memBusPkg.sv
logic/lsuPkg.sv
logic/loadStoreBuffer.sv
logic/dataCache.sv
logic/memCtrl.sv
logic/lsuTop.sv
verification/clockGen.sv
verification/lsu_assertions.sv
verification/lsuTb.sv
